//--- project.f
common/core_pkg.sv
common/fetch_pkg.sv
common/fetch_if.sv
fetch/fetch_unit.sv
fetch/fetch_fifo.sv
exec/exec_unit.sv
hdl/core_top.sv
sim/core_assertions.sv
sim/tb_core_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_core_top -f project.f -o sim_core

./obj_dir/sim_core > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
grep -q "TESTBENCH PASSED" sim.log

//--- sim/tb_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_core_top
  import core_pkg::*;
  import fetch_pkg::*;
();

  localparam addr_t       BOOT      = 32'h0000_1000;
  localparam int unsigned NUM_PROG  = 17;
  localparam int unsigned WAIT_MAX  = 200;
  // Jump targets of the two JALs in the program
  localparam addr_t       TGT_SKIP  = BOOT + 32'h30;
  localparam addr_t       TGT_SPIN  = BOOT + 32'h40;

  logic     clk;
  logic     rst_ni;
  logic     fetch_enable_i;
  addr_t    boot_addr_i;
  logic     instr_req_o;
  addr_t    instr_addr_o;
  logic     instr_gnt_i;
  logic     instr_rvalid_i;
  word_t    instr_rdata_i;
  logic     retire_valid_o;
  addr_t    retire_pc_o;
  reg_idx_t retire_rd_o;
  word_t    retire_wdata_o;
  logic     retire_illegal_o;

  // Program table
  word_t    prog_instr [NUM_PROG];
  logic     exp_retire [NUM_PROG];
  reg_idx_t exp_rd     [NUM_PROG];
  word_t    exp_wdata  [NUM_PROG];
  logic     exp_ill    [NUM_PROG];

  // Memory model state
  logic        pend;
  addr_t       pend_addr;
  int unsigned rv_wait;
  int unsigned gnt_wait;
  logic        req_open;
  logic        first_req;
  addr_t       last_addr;

  core_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////
  // Checks
  ////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input word_t act, input word_t exp);
    if (act !== exp) stop_run($sformatf("FAIL %s: got %h, expected %h", name, act, exp));
  endtask

  task automatic check_reg(input string name, input reg_idx_t act, input reg_idx_t exp);
    if (act !== exp) stop_run($sformatf("FAIL %s: got %h, expected %h", name, act, exp));
  endtask

  task automatic check_addr(input string name, input addr_t act, input addr_t exp);
    if (act !== exp) stop_run($sformatf("FAIL %s: got %h, expected %h", name, act, exp));
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) stop_run($sformatf("FAIL %s: got %h, expected %h", name, act, exp));
  endtask

  ////////////////////////////////
  // Encoders built from the ISA formats
  ////////////////////////////////

  function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                  reg_idx_t rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1, reg_idx_t rd);
    return {f7, rs2, rs1, F3_ADD_SUB, rd, OPC_OP};
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic word_t enc_j(logic [20:0] off, reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  task automatic set_entry(input int idx, input word_t ins, input logic ret, input reg_idx_t rd,
                           input word_t wdata, input logic ill);
    prog_instr[idx] = ins;
    exp_retire[idx] = ret;
    exp_rd[idx]     = rd;
    exp_wdata[idx]  = wdata;
    exp_ill[idx]    = ill;
  endtask

  // Word addressed memory with the program at the boot address
  function automatic word_t read_mem(addr_t addr);
    addr_t idx;
    idx = (addr - BOOT) >> 2;
    if (idx < NUM_PROG) return prog_instr[idx];
    return '0;
  endfunction

  // Sequential climb unless the address is a jump target
  task automatic track_request(input addr_t addr);
    if (first_req) begin
      check_addr("instr_addr_o", addr, BOOT);
    end else if (addr != TGT_SKIP && addr != TGT_SPIN) begin
      check_addr("instr_addr_o", addr, last_addr + INSTR_STEP);
    end
    first_req = 1'b0;
    last_addr = addr;
  endtask

  ////////////////////////////////
  // Instruction memory model
  ////////////////////////////////

  initial begin
    // Fixed seed for the gnt and rvalid delays
    void'($urandom(32'h84fa_4239));
    forever begin
      @(posedge clk);
      instr_rvalid_i <= 1'b0;
      if (!rst_ni) begin
        instr_gnt_i <= 1'b0;
        pend        <= 1'b0;
        gnt_wait    <= $urandom_range(3, 0);
        req_open    = 1'b0;
        first_req   = 1'b1;
      end else begin
        if (pend) begin
          if (rv_wait == 0) begin
            instr_rvalid_i <= 1'b1;
            instr_rdata_i  <= read_mem(pend_addr);
            pend           <= 1'b0;
          end else begin
            rv_wait <= rv_wait - 1;
          end
        end
        if (instr_req_o && !req_open) begin
          req_open = 1'b1;
          track_request(instr_addr_o);
        end
        // Grant seen so the response follows after a random delay
        if (instr_req_o && instr_gnt_i) begin
          instr_gnt_i <= 1'b0;
          pend        <= 1'b1;
          pend_addr   <= instr_addr_o;
          rv_wait     <= $urandom_range(3, 0);
          gnt_wait    <= $urandom_range(3, 0);
          req_open    = 1'b0;
        end else if (instr_req_o) begin
          if (gnt_wait == 0) instr_gnt_i <= 1'b1;
          else gnt_wait <= gnt_wait - 1;
        end
      end
    end
  end

  task automatic wait_retire();
    int cnt;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (!retire_valid_o && cnt < WAIT_MAX);
    if (!retire_valid_o) stop_run("Timeout: no instruction retired");
  endtask

  // Quiet means no request, nothing in flight, no retire for 16 cycles
  task automatic wait_quiet();
    int cnt;
    int calm;
    cnt  = 0;
    calm = 0;
    while (calm < 16 && cnt < 4 * WAIT_MAX) begin
      @(negedge clk);
      cnt++;
      if (instr_req_o || pend || retire_valid_o) calm = 0;
      else calm++;
    end
    if (calm < 16) stop_run("Timeout: core did not go quiet after fetch was disabled");
  endtask

  ////////////////////////////////
  // Main sequence
  ////////////////////////////////

  initial begin
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;

    // Expected values worked out by hand
    set_entry(0,  enc_u(20'h12345, 5'd1),                  1, 5'd1,  32'h1234_5000, 0);
    set_entry(1,  enc_i(12'h678, 5'd1, F3_ADD_SUB, 5'd2),  1, 5'd2,  32'h1234_5678, 0);
    set_entry(2,  enc_i(12'hffb, 5'd0, F3_ADD_SUB, 5'd4),  1, 5'd4,  32'hffff_fffb, 0);
    set_entry(3,  enc_i(12'hffc, 5'd4, F3_SLT, 5'd3),      1, 5'd3,  32'h0000_0001, 0);
    set_entry(4,  enc_i(12'h0ff, 5'd2, F3_XOR, 5'd5),      1, 5'd5,  32'h1234_5687, 0);
    set_entry(5,  enc_i(12'h700, 5'd3, F3_OR, 5'd6),       1, 5'd6,  32'h0000_0701, 0);
    set_entry(6,  enc_i(12'h0f0, 5'd5, F3_AND, 5'd7),      1, 5'd7,  32'h0000_0080, 0);
    set_entry(7,  enc_r(FUNCT7_ADD, 5'd7, 5'd2, 5'd8),     1, 5'd8,  32'h1234_56f8, 0);
    set_entry(8,  enc_r(FUNCT7_SUB, 5'd1, 5'd8, 5'd9),     1, 5'd9,  32'h0000_06f8, 0);
    // JAL over two words
    set_entry(9,  enc_j(21'd12, 5'd10),                    1, 5'd10, BOOT + 32'h28, 0);
    set_entry(10, enc_i(12'h001, 5'd0, F3_ADD_SUB, 5'd11), 0, 5'd0,  32'h0, 0);
    set_entry(11, enc_i(12'h002, 5'd0, F3_ADD_SUB, 5'd11), 0, 5'd0,  32'h0, 0);
    // custom-0 opcode aimed at x9
    set_entry(12, 32'h0000_048b,                           1, 5'd0,  32'h0, 1);
    set_entry(13, enc_r(FUNCT7_ADD, 5'd0, 5'd9, 5'd12),    1, 5'd12, 32'h0000_06f8, 0);
    set_entry(14, enc_i(12'h005, 5'd2, F3_ADD_SUB, 5'd0),  1, 5'd0,  32'h0, 0);
    set_entry(15, enc_r(FUNCT7_ADD, 5'd0, 5'd0, 5'd13),    1, 5'd13, 32'h0, 0);
    // Spin on itself
    set_entry(16, enc_j(21'd0, 5'd0),                      1, 5'd0,  32'h0, 0);

    repeat (3) @(posedge clk);
    rst_ni <= 1'b1;

    // Idle while fetch is disabled
    repeat (5) begin
      @(negedge clk);
      check_bit("instr_req_o", instr_req_o, 1'b0);
      check_bit("retire_valid_o", retire_valid_o, 1'b0);
    end
    @(posedge clk);
    fetch_enable_i <= 1'b1;

    for (int i = 0; i < NUM_PROG; i++) begin
      if (exp_retire[i]) begin
        wait_retire();
        check_addr("retire_pc_o", retire_pc_o, BOOT + addr_t'(4 * i));
        check_reg("retire_rd_o", retire_rd_o, exp_rd[i]);
        check_word("retire_wdata_o", retire_wdata_o, exp_wdata[i]);
        check_bit("retire_illegal_o", retire_illegal_o, exp_ill[i]);
      end
    end

    // Drain with fetch off
    @(posedge clk);
    fetch_enable_i <= 1'b0;
    wait_quiet();
    repeat (20) begin
      @(negedge clk);
      check_bit("instr_req_o", instr_req_o, 1'b0);
      check_bit("retire_valid_o", retire_valid_o, 1'b0);
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/core_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module core_assertions
  import core_pkg::*;
  import fetch_pkg::*;
(
  input wire logic     clk,
  input wire logic     rst_ni,
  input wire logic     instr_req_o,
  input wire addr_t    instr_addr_o,
  input wire logic     instr_gnt_i,
  input wire logic     instr_rvalid_i,
  input wire logic     retire_illegal_o,
  input wire reg_idx_t retire_rd_o
);

  // One granted fetch waiting for its data
  logic outstanding_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
    end else if (instr_req_o && instr_gnt_i) begin
      outstanding_q <= 1'b1;
    end else if (instr_rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  req_held: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("request dropped or address changed before grant");

  rvalid_owned: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_rvalid_i |-> outstanding_q)
    else $error("rvalid without an outstanding request");

  illegal_no_rd: assert property (@(posedge clk) disable iff (!rst_ni)
    retire_illegal_o |-> retire_rd_o == '0)
    else $error("illegal retire reports a destination register");

endmodule

bind core_top core_assertions u_core_assertions (.*);

`default_nettype wire

//--- hdl/core_top.sv
`timescale 1ns/100ps
`default_nettype none

module core_top
  import core_pkg::*;
  import fetch_pkg::*;
(
  input  logic     clk,
  input  logic     rst_ni,

  input  logic     fetch_enable_i,
  input  addr_t    boot_addr_i,

  // Instruction memory
  output logic     instr_req_o,
  output addr_t    instr_addr_o,
  input  logic     instr_gnt_i,
  input  logic     instr_rvalid_i,
  input  word_t    instr_rdata_i,

  // Retire port
  output logic     retire_valid_o,
  output addr_t    retire_pc_o,
  output reg_idx_t retire_rd_o,
  output word_t    retire_wdata_o,
  output logic     retire_illegal_o
);

  // Redirect from execute to fetch and buffer
  logic  redirect;
  addr_t redirect_pc;

  fetch_if fetch_bus ();

  //////////////////////////////
  // Front end
  //////////////////////////////

  fetch_unit u_fetch_unit (
    .clk            ( clk            ),
    .rst_ni         ( rst_ni         ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .redirect_i     ( redirect       ),
    .redirect_pc_i  ( redirect_pc    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .fifo           ( fetch_bus      )
  );

  // Flushed by the same redirect pulse
  fetch_fifo u_fetch_fifo (
    .clk     ( clk       ),
    .rst_ni  ( rst_ni    ),
    .flush_i ( redirect  ),
    .fifo    ( fetch_bus )
  );

  //////////////////////////////
  // Execute
  //////////////////////////////

  exec_unit u_exec_unit (
    .clk              ( clk              ),
    .rst_ni           ( rst_ni           ),
    .fifo             ( fetch_bus        ),
    .redirect_o       ( redirect         ),
    .redirect_pc_o    ( redirect_pc      ),
    .retire_valid_o   ( retire_valid_o   ),
    .retire_pc_o      ( retire_pc_o      ),
    .retire_rd_o      ( retire_rd_o      ),
    .retire_wdata_o   ( retire_wdata_o   ),
    .retire_illegal_o ( retire_illegal_o )
  );

endmodule

`default_nettype wire

//--- exec/exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module exec_unit
  import core_pkg::*;
  import fetch_pkg::*;
(
  input  logic      clk,
  input  logic      rst_ni,

  fetch_if.consumer fifo,

  // JAL redirect, one cycle pulse
  output logic      redirect_o,
  output addr_t     redirect_pc_o,

  // Retire port, registered
  output logic      retire_valid_o,
  output addr_t     retire_pc_o,
  output reg_idx_t  retire_rd_o,
  output word_t     retire_wdata_o,
  output logic      retire_illegal_o
);

  word_t    regs [NUM_REGS];

  word_t    instr;
  addr_t    pc;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    imm_val;
  word_t    result;
  addr_t    target;
  logic     illegal;
  logic     is_jal;
  logic     wen;
  logic     pop;
  logic     redirect_q;

  // Head entry fields
  assign instr  = fifo.head.instr;
  assign pc     = fifo.head.pc;
  assign rd     = get_rd(instr);
  assign rs1    = get_rs1(instr);
  assign rs2    = get_rs2(instr);
  assign funct3 = get_funct3(instr);
  assign funct7 = get_funct7(instr);

  // x0 hardwired to zero on read
  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];
  assign imm_val = imm_i(instr);

  // Head is stale while the flush is pending
  assign pop      = fifo.valid & ~redirect_q;
  assign fifo.pop = pop;

  //////////////////////////////
  // Decode and ALU
  //////////////////////////////

  always_comb begin
    result  = '0;
    illegal = 1'b0;
    is_jal  = 1'b0;
    target  = pc + imm_j(instr);

    case (get_opcode(instr))
      OPC_OP_IMM: begin
        case (funct3)
          F3_ADD_SUB: result = rs1_val + imm_val;
          F3_SLT:     result = {{(XLEN-1){1'b0}}, $signed(rs1_val) < $signed(imm_val)};
          F3_XOR:     result = rs1_val ^ imm_val;
          F3_OR:      result = rs1_val | imm_val;
          F3_AND:     result = rs1_val & imm_val;
          default:    illegal = 1'b1;
        endcase
      end
      // Only ADD and SUB among register ops
      OPC_OP: begin
        if (funct3 != F3_ADD_SUB) begin
          illegal = 1'b1;
        end else if (funct7 == FUNCT7_SUB) begin
          result = rs1_val - rs2_val;
        end else if (funct7 == FUNCT7_ADD) begin
          result = rs1_val + rs2_val;
        end else begin
          illegal = 1'b1;
        end
      end
      OPC_LUI: result = imm_u(instr);
      // Link value
      OPC_JAL: begin
        result = pc + INSTR_STEP;
        is_jal = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
  end

  assign wen = ~illegal & (rd != '0);

  // Register file, written at the pop edge
  always_ff @(posedge clk) begin
    if (pop && wen) begin
      regs[rd] <= result;
    end
  end

  //////////////////////////////
  // Retire and redirect
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      retire_valid_o   <= 1'b0;
      retire_illegal_o <= 1'b0;
      redirect_q       <= 1'b0;
    end else begin
      retire_valid_o   <= pop;
      retire_illegal_o <= pop & illegal;
      redirect_q       <= pop & is_jal;
    end
  end

  // Nothing written shows as rd 0, data 0
  always_ff @(posedge clk) begin
    retire_pc_o    <= pc;
    retire_rd_o    <= wen ? rd : '0;
    retire_wdata_o <= wen ? result : '0;
    redirect_pc_o  <= target;
  end

  assign redirect_o = redirect_q;

endmodule

`default_nettype wire

//--- fetch/fetch_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_fifo
  import fetch_pkg::*;
(
  input  logic    clk,
  input  logic    rst_ni,

  // Redirect flush, empties at the next edge
  input  logic    flush_i,

  fetch_if.buffer fifo
);

  fetch_entry_t mem [FETCH_DEPTH];

  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  fifo_cnt_t cnt_q, cnt_d;
  logic      full;
  logic      push_ok;
  logic      pop_ok;

  assign full = (cnt_q == fifo_cnt_t'(FETCH_DEPTH));

  // Push in a flush cycle is lost on purpose
  assign push_ok = fifo.push & (~full | fifo.pop) & ~flush_i;
  assign pop_ok  = fifo.pop & fifo.valid;

  // Occupancy update
  always_comb begin
    cnt_d = cnt_q;
    if (push_ok && !pop_ok) begin
      cnt_d = cnt_q + 1'b1;
    end else if (!push_ok && pop_ok) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  //////////////////////////////
  // Pointers and count
  //////////////////////////////

  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_ok) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_ok)  rd_ptr_q <= rd_ptr_q + 1'b1;
      cnt_q <= cnt_d;
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr_q] <= fifo.push_entry;
    end
  end

  assign fifo.valid = (cnt_q != '0);
  assign fifo.head  = mem[rd_ptr_q];
  assign fifo.space = (cnt_q <= fifo_cnt_t'(FETCH_DEPTH - FETCH_SPACE_MIN));

endmodule

`default_nettype wire

//--- fetch/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
  import core_pkg::*;
  import fetch_pkg::*;
(
  input  logic      clk,
  input  logic      rst_ni,

  input  logic      fetch_enable_i,
  input  addr_t     boot_addr_i,

  // Redirect from execute
  input  logic      redirect_i,
  input  addr_t     redirect_pc_i,

  // Instruction memory, req/gnt/rvalid
  output logic      instr_req_o,
  output addr_t     instr_addr_o,
  input  logic      instr_gnt_i,
  input  logic      instr_rvalid_i,
  input  word_t     instr_rdata_i,

  fetch_if.producer fifo
);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_RVALID
  } fetch_state_e;

  fetch_state_e state_q, state_d;
  addr_t        fetch_pc_q, fetch_pc_d;
  addr_t        req_addr_q, req_addr_d;
  logic         discard_q, discard_d;
  logic         booted_q;
  logic         start_req;

  // New fetch allowed, free slots checked only here
  // Never raise in a redirect cycle, the PC is stale then
  assign start_req = fetch_enable_i & booted_q & fifo.space & ~redirect_i;

  //////////////////////////////
  // Request FSM
  //////////////////////////////

  always_comb begin
    state_d    = state_q;
    fetch_pc_d = fetch_pc_q;
    req_addr_d = req_addr_q;
    discard_d  = discard_q;

    case (state_q)
      IDLE: begin
        if (start_req) begin
          state_d    = REQ;
          req_addr_d = fetch_pc_q;
          fetch_pc_d = fetch_pc_q + INSTR_STEP;
        end
      end
      // Hold req and addr until granted
      REQ: begin
        if (instr_gnt_i) begin
          state_d = WAIT_RVALID;
        end
      end
      WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          discard_d = 1'b0;
          // Back to back: next request in the cycle after rvalid
          if (start_req) begin
            state_d    = REQ;
            req_addr_d = fetch_pc_q;
            fetch_pc_d = fetch_pc_q + INSTR_STEP;
          end else begin
            state_d = IDLE;
          end
        end
      end
      default: state_d = IDLE;
    endcase

    // Jump target wins over sequential PC
    if (redirect_i) begin
      fetch_pc_d = redirect_pc_i;
      // In-flight fetch belongs to the old path
      if ((state_q == REQ) || ((state_q == WAIT_RVALID) && !instr_rvalid_i)) begin
        discard_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      fetch_pc_q <= '0;
      discard_q  <= 1'b0;
      booted_q   <= 1'b0;
    end else begin
      state_q   <= state_d;
      discard_q <= discard_d;
      booted_q  <= 1'b1;
      // First cycle out of reset picks up the boot address
      fetch_pc_q <= booted_q ? fetch_pc_d : boot_addr_i;
    end
  end

  always_ff @(posedge clk) begin
    req_addr_q <= req_addr_d;
  end

  assign instr_req_o  = (state_q == REQ);
  assign instr_addr_o = req_addr_q;

  // Response pushed in its rvalid cycle, tagged with the request address
  assign fifo.push       = (state_q == WAIT_RVALID) & instr_rvalid_i & ~discard_q;
  assign fifo.push_entry = '{pc: req_addr_q, instr: instr_rdata_i};

endmodule

`default_nettype wire

//--- common/fetch_if.sv
`timescale 1ns/100ps
`default_nettype none

interface fetch_if
  import fetch_pkg::*;
();

  // Write side, fetch unit into buffer
  logic         push;
  fetch_entry_t push_entry;
  logic         space;

  // Read side, buffer head to execute
  logic         valid;
  fetch_entry_t head;
  logic         pop;

  modport producer (
    output push,
    output push_entry,
    input  space
  );

  modport buffer (
    input  push,
    input  push_entry,
    output space,
    output valid,
    output head,
    input  pop
  );

  modport consumer (
    input  valid,
    input  head,
    output pop
  );

endinterface

`default_nettype wire

//--- common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // Prefetch buffer geometry
  localparam int unsigned FETCH_DEPTH = 4;
  localparam int unsigned FIFO_PTR_W  = $clog2(FETCH_DEPTH);

  // Free slots needed before a new request goes out
  // one for the entry landing now, one for the new fetch
  localparam int unsigned FETCH_SPACE_MIN = 2;

  typedef logic [$clog2(FETCH_DEPTH+1)-1:0] fifo_cnt_t;
  typedef logic [FIFO_PTR_W-1:0]            fifo_ptr_t;

  typedef logic [31:0] addr_t;

  // One fetched word tagged with its address
  typedef struct packed {
    addr_t       pc;
    logic [31:0] instr;
  } fetch_entry_t;

endpackage

`default_nettype wire

//--- common/core_pkg.sv
`default_nettype none

package core_pkg;

  // Datapath width and register file size
  localparam int unsigned XLEN     = 32;
  localparam int unsigned NUM_REGS = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // funct3 encodings, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 of OP, plain add vs. subtract
  localparam logic [6:0] FUNCT7_ADD = 7'b0000000;
  localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

  // Sequential PC step, no compressed forms
  localparam logic [31:0] INSTR_STEP = 32'd4;

  //////////////////////////////
  // Instruction field helpers
  //////////////////////////////

  function automatic logic [6:0] get_opcode(word_t instr);
    return instr[6:0];
  endfunction

  function automatic logic [2:0] get_funct3(word_t instr);
    return instr[14:12];
  endfunction

  function automatic logic [6:0] get_funct7(word_t instr);
    return instr[31:25];
  endfunction

  function automatic reg_idx_t get_rd(word_t instr);
    return instr[11:7];
  endfunction

  function automatic reg_idx_t get_rs1(word_t instr);
    return instr[19:15];
  endfunction

  function automatic reg_idx_t get_rs2(word_t instr);
    return instr[24:20];
  endfunction

  // Sign extended I-type immediate
  function automatic word_t imm_i(word_t instr);
    return {{20{instr[31]}}, instr[31:20]};
  endfunction

  // Upper immediate, low 12 bits zero
  function automatic word_t imm_u(word_t instr);
    return {instr[31:12], 12'b0};
  endfunction

  // J-type offset, scrambled bit order, bit 0 always zero
  function automatic word_t imm_j(word_t instr);
    return {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  endfunction

endpackage

`default_nettype wire
